//--- build.f
design/l2_cache_pkg.sv
design/l2_cache_control.sv
design/lru_age_counters.sv
design/tag_meta_array.sv
design/data_line_array.sv
design/l2_cache.sv
verif/l2_cache_tb.sv

//--- verif/l2_cache_tb.sv
// Runs 8 ways only; memory answers after 1 to 4 cycles, every wait gives up after 200 cycles.
`default_nettype none

module l2_cache_tb
    import l2_cache_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ways = 8;

    logic clk;
    logic rst;
    logic [31:0] mem_address;
    logic mem_read;
    logic mem_write;
    byte_en_t mem_byte_enable256;
    line_t mem_wdata256;
    line_t mem_rdata256;
    logic mem_resp;
    line_t pmem_rdata;
    logic pmem_resp;
    logic [31:0] pmem_address;
    logic pmem_read;
    logic pmem_write;
    line_t pmem_wdata;
    logic started = 1'b0;

    // Memory contents and the strobes seen during one access.
    line_t mem [logic [31:0]];
    logic ev_write [$];
    l2_addr_u ev_addr [$];
    line_t ev_data [$];

    // Shadow copy of the cache.
    logic [tag_bits-1:0] ref_tag [num_sets][ways];
    logic ref_valid [num_sets][ways];
    logic ref_dirty [num_sets][ways];
    int ref_age [num_sets][ways];
    line_t ref_data [num_sets][ways];
    line_t ref_mem [logic [31:0]];

    l2_cache #(.num_ways(ways)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ********************
    // Helpers.
    // ********************
    function automatic line_t fill_line(input logic [31:0] addr);
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = addr ^ (32'h9e37_79b9 * (i + 1));
        end
        return l;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = $urandom();
        end
        return l;
    endfunction

    function automatic l2_addr_u make_addr(input int tag, input int set, input int off);
        l2_addr_u a;
        a.f.tag = tag_bits'(tag);
        a.f.set_idx = set_bits'(set);
        a.f.offset = offset_bits'(off);
        return a;
    endfunction

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "line mismatch");
        end
    endtask

    task automatic check_addr(input string name, input l2_addr_u exp, input l2_addr_u act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp.raw, act.raw);
            $display("TEST FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic report_timeout(input string name);
        $display("%s: the cache gave no response within 200 cycles", name);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    endtask

    // ********************
    // Reference model.
    // ********************
    function automatic void ref_access(input l2_addr_u a, input logic wr, input byte_en_t be,
                                       input line_t wd, output line_t rdata, output int victim,
                                       output logic miss, output logic wb,
                                       output l2_addr_u wb_addr, output line_t wb_data);
        int s;
        int way;
        int old_age;
        l2_addr_u line_addr;
        s = a.f.set_idx;
        way = -1;
        victim = 0;
        wb = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (int w = 0; w < ways; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == a.f.tag) begin
                way = w;
            end
            if (ref_age[s][w] == ways - 1) begin
                victim = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            if (ref_valid[s][victim] && ref_dirty[s][victim]) begin
                wb = 1'b1;
                wb_addr = make_addr(ref_tag[s][victim], s, 0);
                wb_data = ref_data[s][victim];
                ref_mem[wb_addr.raw] = wb_data;
            end
            line_addr = make_addr(a.f.tag, s, 0);
            ref_data[s][victim] = ref_mem.exists(line_addr.raw) ? ref_mem[line_addr.raw]
                                                                : fill_line(line_addr.raw);
            ref_tag[s][victim] = a.f.tag;
            ref_valid[s][victim] = 1'b1;
            ref_dirty[s][victim] = 1'b0;
            way = victim;
        end
        rdata = ref_data[s][way];
        if (wr) begin
            for (int b = 0; b < line_bits / 8; b++) begin
                if (be[b]) begin
                    ref_data[s][way][b*8 +: 8] = wd[b*8 +: 8];
                end
            end
            ref_dirty[s][way] = 1'b1;
        end
        old_age = ref_age[s][way];
        for (int w = 0; w < ways; w++) begin
            if (w == way) begin
                ref_age[s][w] = 0;
            end else if (ref_age[s][w] < old_age) begin
                ref_age[s][w]++;
            end
        end
    endfunction

    // Physical memory, one strobe at a time.
    initial begin : memory_model
        int unsigned delay;
        forever begin
            @(negedge clk);
            if (!rst && (pmem_read || pmem_write)) begin
                ev_write.push_back(pmem_write);
                ev_addr.push_back(l2_addr_u'(pmem_address));
                ev_data.push_back(pmem_wdata);
                delay = $urandom_range(1, 4);
                repeat (delay) @(negedge clk);
                if (pmem_write) begin
                    mem[pmem_address] = pmem_wdata;
                end else begin
                    pmem_rdata = mem.exists(pmem_address) ? mem[pmem_address]
                                                          : fill_line(pmem_address);
                end
                pmem_resp = 1'b1;
                @(negedge clk);
                pmem_resp = 1'b0;
            end
        end
    end

    // Outputs stay quiet until the first request.
    initial begin : quiet_check
        for (int i = 0; i < 200 && !started; i++) begin
            @(negedge clk);
            if (!started) begin
                check_bit("quiet mem_resp", 1'b0, mem_resp);
                check_bit("quiet pmem_read", 1'b0, pmem_read);
                check_bit("quiet pmem_write", 1'b0, pmem_write);
            end
        end
    end

    task automatic do_access(input string name, input l2_addr_u a, input logic wr,
                             input byte_en_t be, input line_t wd);
        line_t exp_rdata;
        line_t exp_wb_data;
        line_t got;
        int exp_victim;
        int waited;
        int last;
        logic exp_miss;
        logic exp_wb;
        l2_addr_u exp_wb_addr;
        ref_access(a, wr, be, wd, exp_rdata, exp_victim, exp_miss, exp_wb, exp_wb_addr,
                   exp_wb_data);
        mem_address = a.raw;
        mem_read = !wr;
        mem_write = wr;
        mem_byte_enable256 = be;
        mem_wdata256 = wd;
        started = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (mem_resp !== 1'b1 && waited < 200);
        if (mem_resp !== 1'b1) begin
            report_timeout(name);
        end else begin
            got = mem_rdata256;
            // Hold through the commit edge.
            @(negedge clk);
            mem_read = 1'b0;
            mem_write = 1'b0;
            check_line({name, " rdata"}, exp_rdata, got);
            if (!exp_miss) begin
                check_bit({name, " hit latency"}, 1'b1, waited == 1);
                check_bit({name, " no strobe"}, 1'b1, ev_write.size() == 0);
            end else begin
                check_bit({name, " strobe count"}, 1'b1, ev_write.size() == (exp_wb ? 2 : 1));
                if (exp_wb) begin
                    check_bit({name, " wb first"}, 1'b1, ev_write[0]);
                    check_addr({name, " wb addr"}, exp_wb_addr, ev_addr[0]);
                    check_line({name, " wb data"}, exp_wb_data, ev_data[0]);
                end
                last = ev_write.size() - 1;
                check_bit({name, " fill read"}, 1'b0, ev_write[last]);
                check_addr({name, " fill addr"}, make_addr(a.f.tag, a.f.set_idx, 0),
                           ev_addr[last]);
            end
        end
        ev_write.delete();
        ev_addr.delete();
        ev_data.delete();
    endtask

    // ********************
    // Test sequence.
    // ********************
    initial begin : test_sequence
        line_t wd;
        void'($urandom(41));
        rst = 1'b1;
        started = 1'b0;
        mem_address = '0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_byte_enable256 = '0;
        mem_wdata256 = '0;
        pmem_rdata = '0;
        pmem_resp = 1'b0;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_age[s][w] = w;
            end
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        do_access("read_miss", make_addr(100, 3, 0), 1'b0, '0, '0);
        do_access("read_hit", make_addr(100, 3, 4), 1'b0, '0, '0);
        wd = rand_line();
        do_access("write_hit", make_addr(100, 3, 0), 1'b1, 32'h0000_f00f, wd);
        do_access("read_merged", make_addr(100, 3, 0), 1'b0, '0, '0);

        // Eight dirty ways, then a ninth tag evicts the oldest.
        for (int t = 1; t <= 8; t++) begin
            do_access("fill_set", make_addr(t, 5, 0), 1'b1, 32'hffff_0000, rand_line());
        end
        do_access("evict_dirty", make_addr(9, 5, 0), 1'b0, '0, '0);

        for (int i = 0; i < 300; i++) begin
            do_access("random", make_addr($urandom_range(0, 11), $urandom_range(0, 2),
                      $urandom_range(0, 31)), 1'($urandom_range(0, 1)), $urandom(), rand_line());
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule : l2_cache_tb

`default_nettype wire

//--- design/l2_cache.sv
// Line-aligned memory traffic only; the request offset is ignored by the cache.
`default_nettype none

module l2_cache
    import l2_cache_pkg::*;
#(
    parameter int num_ways = 8
) (
    input  wire          clk,
    input  wire          rst,
    input  wire [31:0]   mem_address,
    input  wire          mem_read,
    input  wire          mem_write,
    input  wire byte_en_t mem_byte_enable256,
    input  wire line_t   mem_wdata256,
    output line_t        mem_rdata256,
    output logic         mem_resp,
    input  wire line_t   pmem_rdata,
    input  wire          pmem_resp,
    output logic [31:0]  pmem_address,
    output logic         pmem_read,
    output logic         pmem_write,
    output line_t        pmem_wdata
);

    l2_addr_u            req_addr;
    l2_addr_u            pmem_addr;
    ctl_cmd_t            cmd;
    logic [num_ways-1:0] hit;
    logic [num_ways-1:0] victim;
    logic                victim_dirty;
    logic [tag_bits-1:0] victim_tag;

    assign req_addr = l2_addr_u'(mem_address);

    // Write-back goes to the victim's line, fill to the request's line.
    always_comb begin
        pmem_addr.f.tag     = cmd.evict_sel ? victim_tag : req_addr.f.tag;
        pmem_addr.f.set_idx = req_addr.f.set_idx;
        pmem_addr.f.offset  = '0;
    end

    assign pmem_address = pmem_addr.raw;

    l2_cache_control #(.num_ways(num_ways)) u_control (
        .clk, .rst, .mem_read, .mem_write, .hit, .victim_dirty, .pmem_resp,
        .cmd, .pmem_read, .pmem_write, .mem_resp
    );

    lru_age_counters #(.num_ways(num_ways)) u_lru (
        .clk, .rst, .set_idx(req_addr.f.set_idx), .cmd, .hit, .victim
    );

    tag_meta_array #(.num_ways(num_ways)) u_tags (
        .clk, .rst, .req_tag(req_addr.f.tag), .set_idx(req_addr.f.set_idx), .cmd,
        .victim, .hit, .victim_dirty, .victim_tag
    );

    data_line_array #(.num_ways(num_ways)) u_data (
        .clk, .set_idx(req_addr.f.set_idx), .cmd, .hit, .victim, .mem_byte_enable256,
        .mem_wdata256, .pmem_rdata, .rdata(mem_rdata256), .victim_line(pmem_wdata)
    );

endmodule : l2_cache

`default_nettype wire

//--- design/data_line_array.sv
// Asynchronous reads; contents are undefined until a way is filled.
`default_nettype none

module data_line_array
    import l2_cache_pkg::*;
#(
    parameter int num_ways = 8
) (
    input  wire                clk,
    input  wire [set_bits-1:0] set_idx,
    input  wire ctl_cmd_t      cmd,
    input  wire [num_ways-1:0] hit,
    input  wire [num_ways-1:0] victim,
    input  wire byte_en_t      mem_byte_enable256,
    input  wire line_t         mem_wdata256,
    input  wire line_t         pmem_rdata,
    output line_t              rdata,
    output line_t              victim_line
);

    line_t lines [num_sets][num_ways];

    // Hit way to requester, victim way to memory.
    always_comb begin
        rdata       = '0;
        victim_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                rdata = rdata | lines[set_idx][w];
            end
            if (victim[w]) begin
                victim_line = victim_line | lines[set_idx][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (cmd.fill && victim[w]) begin
                lines[set_idx][w] <= pmem_rdata;
            end else if (cmd.store && hit[w]) begin
                for (int b = 0; b < line_bits / 8; b++) begin
                    if (mem_byte_enable256[b]) begin
                        lines[set_idx][w][b*8 +: 8] <= mem_wdata256[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule : data_line_array

`default_nettype wire

//--- design/tag_meta_array.sv
// Tags are written only on fill; fill and store never come in the same cycle.
`default_nettype none

module tag_meta_array
    import l2_cache_pkg::*;
#(
    parameter int num_ways = 8
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [tag_bits-1:0]   req_tag,
    input  wire [set_bits-1:0]   set_idx,
    input  wire ctl_cmd_t        cmd,
    input  wire [num_ways-1:0]   victim,
    output logic [num_ways-1:0]  hit,
    output logic                 victim_dirty,
    output logic [tag_bits-1:0]  victim_tag
);

    logic [tag_bits-1:0] tags  [num_sets][num_ways];
    logic [num_ways-1:0] valid [num_sets];
    logic [num_ways-1:0] dirty [num_sets];

    // ********************
    // Lookup.
    // ********************
    always_comb begin
        victim_tag = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid[set_idx][w] && (tags[set_idx][w] == req_tag);
            if (victim[w]) begin
                victim_tag = victim_tag | tags[set_idx][w];
            end
        end
    end

    assign victim_dirty = |(victim & valid[set_idx] & dirty[set_idx]);

    // ********************
    // Update.
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else if (cmd.fill) begin
            valid[set_idx] <= valid[set_idx] | victim;
            dirty[set_idx] <= dirty[set_idx] & ~victim;
        end else if (cmd.store) begin
            dirty[set_idx] <= dirty[set_idx] | hit;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.fill) begin
            for (int w = 0; w < num_ways; w++) begin
                if (victim[w]) begin
                    tags[set_idx][w] <= req_tag;
                end
            end
        end
    end

    // A fill only follows a miss, so a tag never lives in two ways.
    a_hit_onehot0: assert property (
        @(posedge clk) disable iff (rst) $onehot0(hit)
    );

endmodule : tag_meta_array

`default_nettype wire

//--- design/lru_age_counters.sv
// Ages per set form a permutation of 0..num_ways-1; the touched way must come as a one-hot hit.
`default_nettype none

module lru_age_counters
    import l2_cache_pkg::*;
#(
    parameter int num_ways = 8
) (
    input  wire                clk,
    input  wire                rst,
    input  wire [set_bits-1:0] set_idx,
    input  wire ctl_cmd_t      cmd,
    input  wire [num_ways-1:0] hit,
    output logic [num_ways-1:0] victim
);

    localparam int age_bits = (num_ways > 1) ? $clog2(num_ways) : 1;

    logic [age_bits-1:0] ages [num_sets][num_ways];
    logic [age_bits-1:0] hit_age;

    // Age of the accessed way.
    always_comb begin
        hit_age = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_age = hit_age | ages[set_idx][w];
            end
        end
    end

    // Oldest way is the victim.
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            victim[w] = (ages[set_idx][w] == age_bits'(num_ways - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    ages[s][w] <= age_bits'(w);
                end
            end
        end else if (cmd.touch) begin
            for (int w = 0; w < num_ways; w++) begin
                if (hit[w]) begin
                    ages[set_idx][w] <= '0;
                end else if (ages[set_idx][w] < hit_age) begin
                    ages[set_idx][w] <= ages[set_idx][w] + 1'b1;
                end
            end
        end
    end

    // Holds only while every update keeps the ages a permutation.
    a_victim_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot(victim)
    );

endmodule : lru_age_counters

`default_nettype wire

//--- design/l2_cache_control.sv
// One requester at a time; requests must be held until mem_resp and memory strobes until pmem_resp.
`default_nettype none

module l2_cache_control
    import l2_cache_pkg::*;
#(
    parameter int num_ways = 8
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                mem_read,
    input  wire                mem_write,
    input  wire [num_ways-1:0] hit,
    input  wire                victim_dirty,
    input  wire                pmem_resp,
    output ctl_cmd_t           cmd,
    output logic               pmem_read,
    output logic               pmem_write,
    output logic               mem_resp
);

    typedef enum logic [2:0] {
        idle,
        cache_access,
        write_back,
        read,
        done
    } state_t;

    state_t state;
    state_t next_state;
    logic   any_hit;

    assign any_hit = |hit;

    // ********************
    // State actions and next state.
    // ********************
    always_comb begin
        cmd        = '0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        mem_resp   = 1'b0;
        next_state = state;
        case (state)
            idle: begin
                if (mem_read || mem_write) begin
                    next_state = cache_access;
                end
            end
            cache_access: begin
                if (any_hit) begin
                    mem_resp   = 1'b1;
                    cmd.touch  = 1'b1;
                    cmd.store  = mem_write;
                    next_state = idle;
                end else if (victim_dirty) begin
                    next_state = write_back;
                end else begin
                    next_state = read;
                end
            end
            write_back: begin
                // Victim tag forms the address.
                pmem_write    = 1'b1;
                cmd.evict_sel = 1'b1;
                if (pmem_resp) begin
                    next_state = read;
                end
            end
            read: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    cmd.fill   = 1'b1;
                    next_state = done;
                end
            end
            done: begin
                // Refilled line hits now.
                mem_resp   = 1'b1;
                cmd.touch  = 1'b1;
                cmd.store  = mem_write;
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // ********************
    // Checks.
    // ********************
    a_pmem_excl: assert property (
        @(posedge clk) disable iff (rst) !(pmem_read && pmem_write)
    );

    // Fill must have landed before the done state answers.
    a_resp_hits: assert property (
        @(posedge clk) disable iff (rst) mem_resp |-> any_hit
    );

endmodule : l2_cache_control

`default_nettype wire

//--- design/l2_cache_pkg.sv
// Set count is fixed at 16 and lines at 32 bytes; the address split depends on both.
`default_nettype none

package l2_cache_pkg;

    // ********************
    // Geometry.
    // ********************
    localparam int line_bits   = 256;
    localparam int offset_bits = 5;
    localparam int set_bits    = 4;
    localparam int num_sets    = 16;
    localparam int tag_bits    = 32 - set_bits - offset_bits;

    typedef logic [line_bits-1:0]   line_t;
    typedef logic [line_bits/8-1:0] byte_en_t;

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set_idx;
        logic [offset_bits-1:0] offset;
    } l2_addr_fields_t;

    // Same word seen raw or split into fields.
    typedef union packed {
        logic [31:0]     raw;
        l2_addr_fields_t f;
    } l2_addr_u;

    // ********************
    // Control to arrays.
    // ********************
    typedef struct packed {
        logic fill;
        logic store;
        logic touch;
        logic evict_sel;
    } ctl_cmd_t;

endpackage : l2_cache_pkg

`default_nettype wire
